/* src/tgen_pkg.sv */
package tgen_pkg;

	// Local bus address width, shared by host side and downstream side
	localparam int BUS_AW = 17;

	// Full 32-bit bus data word
	typedef logic [31:0] word_t;

	// One program memory word
	// Holds a delay, a target address or one data half
	typedef logic [15:0] half_t;

	// Local bus address
	typedef logic [BUS_AW-1:0] bus_addr_t;

	// Upper address bits placed above a program's 16-bit target address
	typedef logic [BUS_AW-17:0] pad_t;

	// Sequencer states
	// Each read state is named after the word that arrives from the RAM in it
	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_DELAY,
		S_RD_ADDR,
		S_RD_LO,
		S_RD_HI,
		S_WAIT
	} seq_state_e;

	// Monitor vector, from MSB down
	// Did-work of previous run, previous bank, current bank, requested bank
	typedef logic [3:0] status_t;

endpackage

/* src/tgen_step_if.sv */
// One program write request, sequencer to bus merger
// A valid strobe means "write this now", there is no back-pressure
interface tgen_step_if;

	// Single-cycle write strobe
	logic valid;

	// Lower 16 bits of the target address
	tgen_pkg::half_t addr;

	// Data halves, joined as {data_hi, data_lo}
	tgen_pkg::half_t data_lo;
	tgen_pkg::half_t data_hi;

	// Sequencer side
	modport src (
		output valid, addr, data_lo, data_hi
	);

	// Merger side
	modport dst (
		input valid, addr, data_lo, data_hi
	);

endinterface

/* src/tgen_delay_timer.sv */
// Post-write delay counter
// Delay is in units of 2**tgen_gran clock cycles
module tgen_delay_timer #(
	parameter int tgen_gran = 0
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,
	input  tgen_pkg::half_t delay,
	output logic            expired
);

	// Counter wide enough for the largest scaled delay
	localparam int CW = 16 + tgen_gran;

	logic [CW-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			// Scale by shifting in zeros at the bottom
			count <= CW'(delay) << tgen_gran;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Zero delay gives expired in the first wait cycle
	assign expired = (count == '0);

endmodule

/* src/tgen_program_ram.sv */
// Two-bank program memory
// Host fills one bank while the sequencer runs the other
module tgen_program_ram #(
	parameter int pcw = 8
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  logic [pcw-1:0]    wr_addr,
	input  tgen_pkg::half_t   wr_data,
	input  logic [pcw-1:0]    rd_addr,
	output tgen_pkg::half_t   rd_data,
	input  logic              trig_take,
	input  logic              bank_next,
	input  logic              did_work,
	output tgen_pkg::status_t status
);

	// Top address bit selects the bank
	tgen_pkg::half_t mem [2**(pcw+1)];

	// Bank flip state, only moves on an accepted trigger
	logic bank;
	logic bank_prev;
	logic work_prev;

	// Sequencer reads the bank the host is not writing
	// On the trigger edge the new bank applies already, so entry 0 comes from it
	logic rd_bank;

	assign rd_bank = trig_take ? ~bank_next : ~bank;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bank <= 1'b0;
			bank_prev <= 1'b0;
			work_prev <= 1'b0;
		end else if (trig_take) begin
			bank <= bank_next;
			bank_prev <= bank;
			work_prev <= did_work;
		end
	end

	// Host write port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[{bank, wr_addr}] <= wr_data;
		end
	end

	// Sequencer read port, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[{rd_bank, rd_addr}];
	end

	assign status = {work_prev, bank_prev, bank, bank_next};

endmodule

/* src/tgen_sequencer.sv */
// Program walker
// Reads four words per entry, issues one write, then waits out the delay
module tgen_sequencer #(
	parameter int pcw = 8
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            trig,
	output logic [pcw-1:0]  rd_addr,
	input  tgen_pkg::half_t rd_data,
	output logic            trig_take,
	output logic            did_work,
	output logic            load,
	output tgen_pkg::half_t delay,
	input  logic            expired,
	tgen_step_if.src        step
);

	tgen_pkg::seq_state_e state;

	// Word index into the active bank, always one read ahead of the data
	logic [pcw-1:0] idx;

	// Captured entry words
	tgen_pkg::half_t delay_q;
	tgen_pkg::half_t addr_q;
	tgen_pkg::half_t lo_q;
	tgen_pkg::half_t hi_q;
	logic valid_q;

	// Triggers only count while idle
	assign trig_take = (state == tgen_pkg::S_IDLE) && trig;
	assign rd_addr = idx;

	// Timer loads as the high half arrives, so the first wait cycle sees the new count
	assign load = (state == tgen_pkg::S_RD_HI);
	assign delay = delay_q;

	assign step.valid = valid_q;
	assign step.addr = addr_q;
	assign step.data_lo = lo_q;
	assign step.data_hi = hi_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= tgen_pkg::S_IDLE;
			idx <= '0;
			valid_q <= 1'b0;
			did_work <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				tgen_pkg::S_IDLE: begin
					// Delay word of entry 0 is already being read
					if (trig_take) begin
						state <= tgen_pkg::S_RD_DELAY;
						idx <= idx + 1'b1;
						did_work <= 1'b0;
					end
				end
				tgen_pkg::S_RD_DELAY: begin
					state <= tgen_pkg::S_RD_ADDR;
					idx <= idx + 1'b1;
				end
				tgen_pkg::S_RD_ADDR: begin
					// Zero address word ends the program, no write and no wait
					if (rd_data == '0) begin
						state <= tgen_pkg::S_IDLE;
						idx <= '0;
					end else begin
						state <= tgen_pkg::S_RD_LO;
						idx <= idx + 1'b1;
					end
				end
				tgen_pkg::S_RD_LO: begin
					state <= tgen_pkg::S_RD_HI;
					idx <= idx + 1'b1;
				end
				tgen_pkg::S_RD_HI: begin
					// Write goes out next cycle
					state <= tgen_pkg::S_WAIT;
					valid_q <= 1'b1;
					did_work <= 1'b1;
				end
				tgen_pkg::S_WAIT: begin
					// idx back at zero means the last entry of the bank is done
					if (expired) begin
						if (idx == '0) begin
							state <= tgen_pkg::S_IDLE;
						end else begin
							state <= tgen_pkg::S_RD_DELAY;
							idx <= idx + 1'b1;
						end
					end
				end
				default: state <= tgen_pkg::S_IDLE;
			endcase
		end
	end

	// Capture each word in the cycle it arrives
	always_ff @(posedge clk) begin
		case (state)
			tgen_pkg::S_RD_DELAY: delay_q <= rd_data;
			tgen_pkg::S_RD_ADDR: addr_q <= rd_data;
			tgen_pkg::S_RD_LO: lo_q <= rd_data;
			tgen_pkg::S_RD_HI: hi_q <= rd_data;
			default: ;
		endcase
	end

endmodule

/* src/tgen_bus_merge.sv */
// Output stage for the downstream bus
// Host pass-through wins, a program write in the same cycle is lost
module tgen_bus_merge (
	input  logic                clk,
	input  logic                rst_n,
	input  tgen_pkg::word_t     lb_data,
	input  tgen_pkg::bus_addr_t lb_addr,
	input  logic                lb_write,
	input  logic                dests_write,
	input  tgen_pkg::pad_t      addr_padding,
	tgen_step_if.dst            step,
	output tgen_pkg::word_t     lbo_data,
	output tgen_pkg::bus_addr_t lbo_addr,
	output logic                lbo_write,
	output logic                collision
);

	// Host write that is not aimed at the program memory
	logic write_thru;

	assign write_thru = lb_write && !dests_write;

	// Strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lbo_write <= 1'b0;
			collision <= 1'b0;
		end else begin
			lbo_write <= write_thru || step.valid;
			// Single-cycle flag, counting is left to the user
			collision <= write_thru && step.valid;
		end
	end

	// Address and data follow whichever source owns the cycle
	always_ff @(posedge clk) begin
		if (write_thru) begin
			lbo_data <= lb_data;
			lbo_addr <= lb_addr;
		end else begin
			lbo_data <= {step.data_hi, step.data_lo};
			lbo_addr <= {addr_padding, step.addr};
		end
	end

endmodule

/* src/tgen_top.sv */
// Timing generator in series with the local register-write bus
// Host writes pass through with one cycle of latency
module tgen_top #(
	// Words per bank is 2**pcw
	parameter int pcw = 8,
	// Delay unit is 2**tgen_gran cycles
	parameter int tgen_gran = 0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                trig,
	// Host bus
	input  tgen_pkg::word_t     lb_data,
	input  logic                lb_write,
	input  tgen_pkg::bus_addr_t lb_addr,
	input  logic                dests_write,
	input  tgen_pkg::pad_t      addr_padding,
	input  logic                bank_next,
	// Downstream bus
	output tgen_pkg::word_t     lbo_data,
	output logic                lbo_write,
	output tgen_pkg::bus_addr_t lbo_addr,
	// Monitoring
	output logic                collision,
	output tgen_pkg::status_t   status
);

	// Sequencer to RAM
	logic [pcw-1:0] rd_addr;
	tgen_pkg::half_t rd_data;
	logic trig_take;
	logic did_work;

	// Sequencer to timer
	logic load;
	tgen_pkg::half_t delay;
	logic expired;

	tgen_step_if step_if ();

	tgen_sequencer #(.pcw(pcw)) u_seq (
		.clk, .rst_n, .trig,
		.rd_addr, .rd_data,
		.trig_take, .did_work,
		.load, .delay, .expired,
		.step (step_if.src)
	);

	tgen_delay_timer #(.tgen_gran(tgen_gran)) u_timer (
		.clk, .rst_n,
		.load, .delay, .expired
	);

	// Program words are the low halves of host writes, indexed by the low address bits
	tgen_program_ram #(.pcw(pcw)) u_ram (
		.clk, .rst_n,
		.wr_en   (dests_write),
		.wr_addr (lb_addr[pcw-1:0]),
		.wr_data (lb_data[15:0]),
		.rd_addr, .rd_data,
		.trig_take, .bank_next, .did_work,
		.status
	);

	tgen_bus_merge u_merge (
		.clk, .rst_n,
		.lb_data, .lb_addr, .lb_write, .dests_write, .addr_padding,
		.step (step_if.dst),
		.lbo_data, .lbo_addr, .lbo_write, .collision
	);

endmodule

/* tests/tgen_chk.sv */
// Protocol checks at the top-level ports and the step strobe
module tgen_chk (
	input logic clk,
	input logic rst_n,
	input logic lbo_write,
	input logic collision,
	input logic step_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Count of failed assertions, seen by the testbench
	int assert_fails = 0;

	// A collision always rides on an output write
	a_coll_write: assert property (@(posedge clk) disable iff (!rst_n) collision |-> lbo_write)
		else begin
			assert_fails++;
			$error("collision high without lbo_write");
		end

	// Outputs stay quiet while reset is held
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !lbo_write && !collision)
		else begin
			assert_fails++;
			$error("output strobe during reset");
		end

	// One strobe per entry, never back to back
	a_step_single: assert property (@(posedge clk) disable iff (!rst_n) step_valid |=> !step_valid)
		else begin
			assert_fails++;
			$error("step valid high in consecutive cycles");
		end

endmodule

/* tests/tgen_tb.sv */
module tgen_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PCW = 6;
	localparam int GRAN = 1;
	localparam int ROUNDS = 8;
	// Upper bound per round covers a load with traffic gaps, the longest run and an idle tail
	localparam int ROUND_CYC = 160;
	localparam int MAX_CYC = 5 + 60 + (ROUNDS + 1) * ROUND_CYC + 10;
	// Margin of two over the worst-case length
	localparam int WATCHDOG_NS = MAX_CYC * 8 * 2;

	logic clk = 1'b0;
	logic rst_n, trig, lb_write, dests_write, bank_next;
	logic lbo_write, collision;
	tgen_pkg::word_t lb_data, lbo_data;
	tgen_pkg::bus_addr_t lb_addr, lbo_addr;
	tgen_pkg::pad_t addr_padding;
	tgen_pkg::status_t status;

	integer seed = 32'hfc141ecd;
	int cyc = 0;

	// Mirror of both banks indexed by {bank, word}
	tgen_pkg::half_t mem_model [2**(PCW+1)];
	logic m_bank, m_bank_prev, m_work_prev, m_run_work;
	// First cycle in which the sequencer is back in idle
	int idle_from = 0;
	// Expected program writes and the cycle of each step strobe
	int valid_cyc [$];
	tgen_pkg::half_t q_addr [$];
	tgen_pkg::word_t q_data [$];
	// What the outputs must show in the next cycle
	logic exp_write, exp_coll;
	tgen_pkg::word_t exp_data;
	tgen_pkg::bus_addr_t exp_addr;

	tgen_top #(.pcw(PCW), .tgen_gran(GRAN)) DUT (
		.clk, .rst_n, .trig,
		.lb_data, .lb_write, .lb_addr, .dests_write, .addr_padding, .bank_next,
		.lbo_data, .lbo_write, .lbo_addr, .collision, .status
	);

	bind tgen_top tgen_chk u_chk (
		.clk(clk), .rst_n(rst_n), .lbo_write(lbo_write),
		.collision(collision), .step_valid(step_if.valid)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input tgen_pkg::word_t got, exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input tgen_pkg::bus_addr_t got, exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_status(input string name, input tgen_pkg::status_t got, exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Build the write schedule of a run whose first read state is cycle start
	task automatic plan_run(input int start, input logic rbank);
		int s;
		int base;
		s = start;
		for (int k = 0; k < 2**PCW / 4; k++) begin
			base = (rbank ? 2**PCW : 0) + 4 * k;
			// Zero address ends the run after two read cycles
			if (mem_model[base + 1] == 16'h0000) begin
				idle_from = s + 2;
				return;
			end
			// Four reads and then the strobe in the first wait cycle
			valid_cyc.push_back(s + 4);
			q_addr.push_back(mem_model[base + 1]);
			q_data.push_back({mem_model[base + 3], mem_model[base + 2]});
			m_run_work = 1'b1;
			s = s + (int'(mem_model[base]) << GRAN) + 5;
		end
		// Wrapped past the last entry
		idle_from = s;
	endtask

	// One cycle that checks outputs, drives inputs and advances the model to the next edge
	task automatic tick(input logic t, input logic wr, input logic dw,
			input tgen_pkg::bus_addr_t a, input tgen_pkg::word_t d);
		logic thru;
		logic prog;
		@(negedge clk);
		cyc++;
		check_bit("lbo_write", lbo_write, exp_write);
		check_bit("collision", collision, exp_coll);
		if (exp_write) begin
			check_addr("lbo_addr", lbo_addr, exp_addr);
			check_word("lbo_data", lbo_data, exp_data);
		end
		check_status("status", status, {m_work_prev, m_bank_prev, m_bank, bank_next});
		if (DUT.u_chk.assert_fails != 0) begin
			$display("A bound protocol assertion failed at %0t", $time);
			abort_run();
		end
		trig = t;
		lb_write = wr;
		dests_write = dw;
		lb_addr = a;
		lb_data = d;
		thru = wr && !dw;
		prog = (valid_cyc.size() > 0) && (valid_cyc[0] == cyc);
		exp_write = thru || prog;
		exp_coll = thru && prog;
		// Host write owns the output and a coinciding program write is lost
		if (thru) begin
			exp_addr = a;
			exp_data = d;
		end else if (prog) begin
			exp_addr = {addr_padding, q_addr[0]};
			exp_data = q_data[0];
		end
		if (prog) begin
			void'(valid_cyc.pop_front());
			void'(q_addr.pop_front());
			void'(q_data.pop_front());
		end
		// Program words land in the host-side bank
		if (dw) begin
			mem_model[{m_bank, a[PCW-1:0]}] = d[15:0];
		end
		if (t && cyc >= idle_from) begin
			m_bank_prev = m_bank;
			m_work_prev = m_run_work;
			m_bank = bank_next;
			m_run_work = 1'b0;
			plan_run(cyc + 1, !bank_next);
		end
	endtask

	// Random host write or idle cycle with an occasional trigger while busy
	task automatic random_traffic();
		logic t;
		t = (cyc + 1 < idle_from) && (($random(seed) & 7) == 0);
		tick(t, $random(seed) & 1, 1'b0, tgen_pkg::bus_addr_t'($random(seed)), $random(seed));
	endtask

	task automatic load_program(input int n);
		tgen_pkg::half_t words [$];
		tgen_pkg::half_t a;
		tgen_pkg::bus_addr_t addr;
		for (int k = 0; k < n; k++) begin
			a = tgen_pkg::half_t'($random(seed));
			if (a == 16'h0000) begin
				a = 16'h0001;
			end
			words.push_back(tgen_pkg::half_t'($random(seed) & 3));
			words.push_back(a);
			words.push_back(tgen_pkg::half_t'($random(seed)));
			words.push_back(tgen_pkg::half_t'($random(seed)));
		end
		// Delay word of the end entry is never used
		words.push_back(tgen_pkg::half_t'($random(seed)));
		words.push_back(16'h0000);
		foreach (words[i]) begin
			if ($random(seed) & 1) begin
				random_traffic();
			end
			addr = tgen_pkg::bus_addr_t'($random(seed));
			addr[PCW-1:0] = PCW'(i);
			tick(1'b0, 1'b1, 1'b1, addr, {16'($random(seed)), words[i]});
		end
	endtask

	task automatic wait_idle();
		while (cyc + 1 < idle_from) begin
			random_traffic();
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, the run did not complete", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		rst_n = 1'b0;
		trig = 1'b0;
		lb_write = 1'b0;
		dests_write = 1'b0;
		lb_addr = '0;
		lb_data = '0;
		addr_padding = '0;
		bank_next = 1'b0;
		{m_bank, m_bank_prev, m_work_prev, m_run_work} = 4'b0000;
		{exp_write, exp_coll} = 2'b00;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Pass-through with stray program memory writes mixed in
		for (int i = 0; i < 60; i++) begin
			if (($random(seed) & 3) == 0) begin
				tick(1'b0, 1'b1, 1'b1, tgen_pkg::bus_addr_t'($random(seed)), $random(seed));
			end else begin
				random_traffic();
			end
		end
		load_program($random(seed) & 7);
		for (int r = 0; r < ROUNDS; r++) begin
			wait_idle();
			// Padding and bank only change while idle
			addr_padding = tgen_pkg::pad_t'($random(seed));
			bank_next = !m_bank;
			tick(1'b1, 1'b0, 1'b0, '0, '0);
			// Next program goes into the bank the host owns now
			load_program($random(seed) & 7);
			wait_idle();
			repeat (3) random_traffic();
		end
		wait_idle();
		repeat (4) random_traffic();
		if (valid_cyc.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Run ended with %0d program writes still expected", valid_cyc.size());
			abort_run();
		end
	end

endmodule

/* list.f */
src/tgen_pkg.sv
src/tgen_step_if.sv
src/tgen_delay_timer.sv
src/tgen_program_ram.sv
src/tgen_sequencer.sv
src/tgen_bus_merge.sv
src/tgen_top.sv
tests/tgen_chk.sv
tests/tgen_tb.sv

/* Bender.yml */
package:
  name: tgen

# RTL in compile order, package and interface first
sources:
  - src/tgen_pkg.sv
  - src/tgen_step_if.sv
  - src/tgen_delay_timer.sv
  - src/tgen_program_ram.sv
  - src/tgen_sequencer.sv
  - src/tgen_bus_merge.sv
  - src/tgen_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - tests/tgen_chk.sv
      - tests/tgen_tb.sv
